/* oflow_buffer.f */
+incdir+src
src/oflow_frame_pkg.sv
src/oflow_mem_pkg.sv
src/oflow_fsm_write.sv
src/oflow_fsm_read.sv
src/oflow_mem_buffer.sv
src/oflow_buffer_top.sv
sim/oflow_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the frame history buffer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=oflow_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module oflow_buffer_tb -f oflow_buffer.f -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sim/oflow_buffer_input.txt */
# C n: history frame count | W hex [n]: write n lines from hex upward, n defaults to 1
# E: end frame | R gap: read, cycles between line and next_line, 0 picks random gaps
C 5
W 00000a00 3
E
E
R 1
W 00000c00 2
E
W 00000d00 18
E
W 00000e00 4
E
W 00000f00 5
E
W 00001000 1
E
R 0
R 2

/* sim/oflow_buffer_tb.sv */
// testbench of the frame history buffer
// clock, reset, commands read from the input file
// reference model of slots, end pointers and read order
`timescale 1ns/1ns
`default_nettype none

`include "oflow_buffer_config.svh"

module oflow_buffer_tb;

	logic clk;
	logic reset_N;
	oflow_frame_pkg::hist_cnt_t num_of_history_frames;
	logic wr_line;
	oflow_mem_pkg::line_t wr_data;
	logic end_frame;
	logic start_read;
	logic next_line;
	logic done_read;
	logic line_valid;
	oflow_mem_pkg::rd_line_t rd_line;
	oflow_frame_pkg::frame_num_t frame_num;
	oflow_frame_pkg::hist_cnt_t counter_of_history_frame;

	// model of slot contents and end pointers
	oflow_mem_pkg::line_t ref_mem [`HIST_SLOTS][`SLOT_DEPTH];
	int ref_end [`HIST_SLOTS];
	// frame being written, lines in it, history count
	int ref_frame;
	int ref_wcnt;
	int ref_hist;
	// lines the next read should return, in order
	oflow_mem_pkg::rd_line_t exp_q[$];
	// history frames walked before each expected line
	int exp_hist_q[$];
	// history frames the next read walks
	int exp_frames;

	int tests;
	int checks;
	int errors;
	bit aborted;

	oflow_buffer_top oflow_buffer_top_inst (
		.clk(clk),
		.reset_N(reset_N),
		.num_of_history_frames(num_of_history_frames),
		.wr_line(wr_line),
		.wr_data(wr_data),
		.end_frame(end_frame),
		.start_read(start_read),
		.next_line(next_line),
		.done_read(done_read),
		.line_valid(line_valid),
		.rd_line(rd_line),
		.frame_num(frame_num),
		.counter_of_history_frame(counter_of_history_frame)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		checks++;
		if (got_val !== exp_val) begin
			errors++;
			$display("ERR %s exp 0x%h got 0x%h", name, exp_val, got_val);
		end
	endtask

	// ------------------------------------------------------------
	// reset and write side
	// ------------------------------------------------------------
	task automatic check_reset();
		int errs;
		errs = errors;
		// 10 cycles in reset, 2 after release
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			check_value("done_read", 32'h0, done_read);
			check_value("line_valid", 32'h0, line_valid);
			check_value("frame_num", 32'h0, frame_num);
			if (i == 9) begin
				reset_N = 1'b1;
			end
		end
		tests++;
		$display("reset: outputs idle, %s", (errs == errors) ? "ok" : "bad");
	endtask

	task automatic write_line(input oflow_mem_pkg::line_t data);
		int slot;
		slot = ref_frame % ref_hist;
		// lines past the slot depth are dropped
		if (ref_wcnt < `SLOT_DEPTH) begin
			ref_mem[slot][ref_wcnt] = data;
			ref_wcnt++;
		end
		wr_line = 1'b1;
		wr_data = data;
		@(negedge clk);
		wr_line = 1'b0;
	endtask

	task automatic close_frame();
		int errs;
		errs = errors;
		ref_end[ref_frame % ref_hist] = ref_wcnt;
		ref_wcnt = 0;
		ref_frame = (ref_frame + 1) % 256;
		end_frame = 1'b1;
		@(negedge clk);
		end_frame = 1'b0;
		tests++;
		check_value("frame_num", ref_frame, frame_num);
		$display("end of frame: frame_num %0d, %s", ref_frame, (errs == errors) ? "ok" : "bad");
	endtask

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	// newest frame first, offsets upward, empty slots give nothing
	task automatic predict_read();
		int frames;
		int f;
		int s;
		oflow_mem_pkg::rd_line_t item;
		exp_q.delete();
		exp_hist_q.delete();
		frames = (ref_frame < ref_hist) ? ref_frame : ref_hist;
		exp_frames = frames;
		for (int h = 0; h < frames; h++) begin
			f = (ref_frame - 1 - h + 256) % 256;
			s = f % ref_hist;
			for (int o = 0; o < ref_end[s]; o++) begin
				item.frame = oflow_frame_pkg::frame_num_t'(f);
				item.offset = oflow_frame_pkg::offset_t'(o);
				item.line = ref_mem[s][o];
				exp_q.push_back(item);
				exp_hist_q.push_back(h);
			end
		end
	endtask

	task automatic run_read(input int gap);
		int errs;
		int total;
		int got;
		int dones;
		int cyc;
		int wait_left;
		int post;
		int exp_h;
		bit pending;
		bit owe;
		bit newest_full;
		oflow_mem_pkg::rd_line_t item;
		errs = errors;
		predict_read();
		total = exp_q.size();
		newest_full = (total > 0) &&
			(exp_q[0].frame == oflow_frame_pkg::frame_num_t'((ref_frame + 255) % 256));
		got = 0;
		dones = 0;
		cyc = 0;
		wait_left = 0;
		post = 0;
		owe = 1'b0;
		// first line comes without a request
		pending = (total > 0);
		start_read = 1'b1;
		while (post < 3 && !aborted) begin
			@(negedge clk);
			cyc++;
			start_read = 1'b0;
			next_line = 1'b0;
			if (cyc > 2000) begin
				errors++;
				aborted = 1'b1;
				$display("read with gap %0d did not finish within 2000 cycles", gap);
			end
			if (done_read) begin
				dones++;
				check_value("counter_of_history_frame", exp_frames,
					counter_of_history_frame);
				if (got != total) begin
					errors++;
					$display("done_read came after %0d of %0d lines", got, total);
				end
			end
			if (dones > 0) begin
				post++;
			end
			if (line_valid) begin
				if (!pending || exp_q.size() == 0) begin
					errors++;
					$display("line_valid came with no request pending");
				end else begin
					item = exp_q.pop_front();
					exp_h = exp_hist_q.pop_front();
					check_value("rd_line.frame", item.frame, rd_line.frame);
					check_value("rd_line.offset", item.offset, rd_line.offset);
					check_value("rd_line.line", item.line, rd_line.line);
					check_value("counter_of_history_frame", exp_h,
						counter_of_history_frame);
					if (got == 0 && newest_full) begin
						check_value("first line_valid cycle", 32'd3, cyc);
					end
				end
				got++;
				pending = 1'b0;
				owe = 1'b1;
				wait_left = (gap == 0) ? int'($urandom % 4) : gap;
			end
			// one next_line per returned line, after the gap
			if (owe) begin
				if (wait_left == 0) begin
					next_line = 1'b1;
					owe = 1'b0;
					pending = (got < total);
				end else begin
					wait_left--;
				end
			end
		end
		next_line = 1'b0;
		if (dones != 1) begin
			errors++;
			$display("done_read pulsed %0d times instead of once", dones);
		end
		check_value("line count", total, got);
		tests++;
		$display("read with gap %0d: %0d lines, %s", gap, got, (errs == errors) ? "ok" : "bad");
	endtask

	// ------------------------------------------------------------
	// command loop
	// ------------------------------------------------------------
	initial begin
		int fd;
		int n;
		int cnt;
		string text;
		logic [7:0] cmd;
		logic [31:0] arg;
		void'($urandom(70));
		reset_N = 1'b0;
		num_of_history_frames = `HIST_SLOTS;
		wr_line = 1'b0;
		wr_data = '0;
		end_frame = 1'b0;
		start_read = 1'b0;
		next_line = 1'b0;
		tests = 0;
		checks = 0;
		errors = 0;
		aborted = 1'b0;
		ref_hist = `HIST_SLOTS;
		ref_frame = 0;
		ref_wcnt = 0;
		exp_frames = 0;
		for (int s = 0; s < `HIST_SLOTS; s++) begin
			ref_end[s] = 0;
		end
		check_reset();
		fd = $fopen("sim/oflow_buffer_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open sim/oflow_buffer_input.txt");
		end else begin
			while (!$feof(fd) && !aborted) begin
				n = $fgets(text, fd);
				// skip blank and comment lines
				if (n > 0 && text[0] != "#" && text[0] != "\n") begin
					cnt = 1;
					n = $sscanf(text, "%c %h %d", cmd, arg, cnt);
					if (n < 3) begin
						cnt = 1;
					end
					case (cmd)
						"C": begin
							num_of_history_frames = oflow_frame_pkg::hist_cnt_t'(arg);
							ref_hist = int'(arg);
							$display("history frames set to %0d", ref_hist);
						end
						"W": begin
							for (int i = 0; i < cnt; i++) begin
								write_line(oflow_mem_pkg::line_t'(arg + 32'(i)));
							end
						end
						"E": close_frame();
						"R": run_read(int'(arg));
						default: begin
							errors++;
							$display("unknown command in input file: %s", text);
						end
					endcase
				end
			end
			$fclose(fd);
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/oflow_buffer_top.sv */
// top level of the frame history buffer
// write controller, read controller and slot memory
`timescale 1ns/1ns
`default_nettype none

`include "oflow_buffer_config.svh"

module oflow_buffer_top (
	input wire logic clk,
	input wire logic reset_N,
	input wire oflow_frame_pkg::hist_cnt_t num_of_history_frames,
	input wire logic wr_line,
	input wire oflow_mem_pkg::line_t wr_data,
	input wire logic end_frame,
	input wire logic start_read,
	input wire logic next_line,
	output logic done_read,
	output logic line_valid,
	output oflow_mem_pkg::rd_line_t rd_line,
	output oflow_frame_pkg::frame_num_t frame_num,
	output oflow_frame_pkg::hist_cnt_t counter_of_history_frame
);

	// write controller to memory and read controller
	logic mem_wr_en;
	oflow_mem_pkg::mem_wr_t mem_wr;
	oflow_frame_pkg::end_ptr_t end_pointers [`HIST_SLOTS];
	// read controller to memory
	logic read_busy;
	logic rd_en;
	oflow_mem_pkg::mem_addr_t rd_addr;
	oflow_frame_pkg::frame_num_t rd_frame;
	oflow_frame_pkg::offset_t rd_offset;

	oflow_fsm_write oflow_fsm_write_inst (
		.clk(clk),
		.reset_N(reset_N),
		.num_of_history_frames(num_of_history_frames),
		.wr_line(wr_line),
		.wr_data(wr_data),
		.end_frame(end_frame),
		.read_busy(read_busy),
		.frame_num(frame_num),
		.end_pointers(end_pointers),
		.mem_wr_en(mem_wr_en),
		.mem_wr(mem_wr)
	);

	oflow_fsm_read oflow_fsm_read_inst (
		.clk(clk),
		.reset_N(reset_N),
		.frame_num(frame_num),
		.num_of_history_frames(num_of_history_frames),
		.end_pointers(end_pointers),
		.start_read(start_read),
		.next_line(next_line),
		.done_read(done_read),
		.read_busy(read_busy),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_frame(rd_frame),
		.rd_offset(rd_offset),
		.counter_of_history_frame(counter_of_history_frame)
	);

	oflow_mem_buffer oflow_mem_buffer_inst (
		.clk(clk),
		.reset_N(reset_N),
		.mem_wr_en(mem_wr_en),
		.mem_wr(mem_wr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_frame(rd_frame),
		.rd_offset(rd_offset),
		.rd_line(rd_line),
		.line_valid(line_valid)
	);

endmodule

`default_nettype wire

/* src/oflow_mem_buffer.sv */
// slot memory of the frame history buffer
// HIST_SLOTS x SLOT_DEPTH lines, one write and one read port
// registered read tagged with frame and offset, valid pulse
`timescale 1ns/1ns
`default_nettype none

`include "oflow_buffer_config.svh"

module oflow_mem_buffer (
	input wire logic clk,
	input wire logic reset_N,
	input wire logic mem_wr_en,
	input wire oflow_mem_pkg::mem_wr_t mem_wr,
	input wire logic rd_en,
	input wire oflow_mem_pkg::mem_addr_t rd_addr,
	input wire oflow_frame_pkg::frame_num_t rd_frame,
	input wire oflow_frame_pkg::offset_t rd_offset,
	output oflow_mem_pkg::rd_line_t rd_line,
	output logic line_valid
);

	// line storage per slot
	oflow_mem_pkg::line_t mem [`HIST_SLOTS][`SLOT_DEPTH];

	// ------------------------------------------------------------
	// write port
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (mem_wr_en) begin
			mem[mem_wr.addr.slot][mem_wr.addr.offset] <= mem_wr.line;
		end
	end

	// ------------------------------------------------------------
	// read port, data one cycle after rd_en
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_line.frame <= rd_frame;
			rd_line.offset <= rd_offset;
			rd_line.line <= mem[rd_addr.slot][rd_addr.offset];
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			line_valid <= 1'b0;
		end else begin
			line_valid <= rd_en;
		end
	end

endmodule

`default_nettype wire

/* src/oflow_fsm_read.sv */
// read controller of the frame history buffer
// walks history frames newest first and lines by offset
// one read per consumer request, empty frames skipped
`timescale 1ns/1ns
`default_nettype none

`include "oflow_buffer_config.svh"

module oflow_fsm_read (
	input wire logic clk,
	input wire logic reset_N,
	input wire oflow_frame_pkg::frame_num_t frame_num,
	input wire oflow_frame_pkg::hist_cnt_t num_of_history_frames,
	input wire oflow_frame_pkg::end_ptr_t end_pointers [`HIST_SLOTS],
	input wire logic start_read,
	input wire logic next_line,
	output logic done_read,
	output logic read_busy,
	output logic rd_en,
	output oflow_mem_pkg::mem_addr_t rd_addr,
	output oflow_frame_pkg::frame_num_t rd_frame,
	output oflow_frame_pkg::offset_t rd_offset,
	output oflow_frame_pkg::hist_cnt_t counter_of_history_frame
);

	oflow_frame_pkg::read_state_t state;
	oflow_frame_pkg::read_state_t next_state;

	// history frames finished so far
	oflow_frame_pkg::hist_cnt_t hist_cnt;
	// offset of the last read issued in this frame
	oflow_frame_pkg::offset_t offset_cnt;
	// first cycle of offset_st, read offset 0
	logic rd_first;

	oflow_frame_pkg::frame_num_t max_frames;
	oflow_frame_pkg::frame_num_t cur_frame;
	oflow_frame_pkg::frame_num_t slot_mod;
	oflow_mem_pkg::slot_t cur_slot;
	oflow_frame_pkg::end_ptr_t cur_end;
	logic hist_done;
	logic last_line;
	logic frame_adv;
	logic off_adv;

	// ------------------------------------------------------------
	// current history frame and its slot
	// ------------------------------------------------------------
	// frames to read, min of frame_num and history count
	assign max_frames = (frame_num < oflow_frame_pkg::frame_num_t'(num_of_history_frames)) ?
		frame_num : oflow_frame_pkg::frame_num_t'(num_of_history_frames);
	assign hist_done = oflow_frame_pkg::frame_num_t'(hist_cnt) >= max_frames;

	// newest first, frame_num-1 down
	assign cur_frame = frame_num - 8'd1 - oflow_frame_pkg::frame_num_t'(hist_cnt);
	assign slot_mod = cur_frame % oflow_frame_pkg::frame_num_t'(num_of_history_frames);
	assign cur_slot = oflow_mem_pkg::slot_t'(slot_mod);
	assign cur_end = end_pointers[cur_slot];

	// the line just read is the frame's last one
	assign last_line = oflow_frame_pkg::end_ptr_t'(offset_cnt) + oflow_frame_pkg::end_ptr_t'(1)
		== cur_end;

	// ------------------------------------------------------------
	// next state and strobes
	// ------------------------------------------------------------
	always_comb begin
		next_state = state;
		done_read = 1'b0;
		rd_en = 1'b0;
		frame_adv = 1'b0;
		off_adv = 1'b0;
		case (state)
			oflow_frame_pkg::idle_st: begin
				if (start_read) begin
					next_state = oflow_frame_pkg::frame_st;
				end
			end
			oflow_frame_pkg::frame_st: begin
				if (hist_done) begin
					done_read = 1'b1;
					next_state = oflow_frame_pkg::idle_st;
				end else if (cur_end == '0) begin
					// empty slot, no read
					frame_adv = 1'b1;
				end else begin
					next_state = oflow_frame_pkg::offset_st;
				end
			end
			oflow_frame_pkg::offset_st: begin
				if (rd_first) begin
					rd_en = 1'b1;
				end else if (next_line) begin
					if (last_line) begin
						frame_adv = 1'b1;
						next_state = oflow_frame_pkg::frame_st;
					end else begin
						rd_en = 1'b1;
						off_adv = 1'b1;
					end
				end
			end
			default: next_state = oflow_frame_pkg::idle_st;
		endcase
	end

	// ------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_frame_pkg::idle_st;
			hist_cnt <= '0;
			offset_cnt <= '0;
			rd_first <= 1'b0;
		end else begin
			state <= next_state;
			rd_first <= (state == oflow_frame_pkg::frame_st) &&
				(next_state == oflow_frame_pkg::offset_st);
			if (state == oflow_frame_pkg::idle_st) begin
				hist_cnt <= '0;
			end else if (frame_adv) begin
				hist_cnt <= hist_cnt + 1'b1;
			end
			// each frame restarts at offset 0
			if (state == oflow_frame_pkg::frame_st) begin
				offset_cnt <= '0;
			end else if (off_adv) begin
				offset_cnt <= offset_cnt + 1'b1;
			end
		end
	end

	// read request toward the memory
	assign rd_offset = rd_first ? offset_cnt : offset_cnt + 1'b1;
	assign rd_addr.slot = cur_slot;
	assign rd_addr.offset = rd_offset;
	assign rd_frame = cur_frame;

	assign read_busy = (state != oflow_frame_pkg::idle_st);
	assign counter_of_history_frame = hist_cnt;

	// never read past what the writer stored
	a_rd_in_range: assert property (
		@(posedge clk) disable iff (!reset_N)
		rd_en |-> oflow_frame_pkg::end_ptr_t'(rd_offset) < end_pointers[rd_addr.slot]
	) else $error("read offset beyond end pointer");

	// done only from frame_st, once every history frame was walked
	a_done_in_frame: assert property (
		@(posedge clk) disable iff (!reset_N)
		done_read |-> (state == oflow_frame_pkg::frame_st) &&
			(oflow_frame_pkg::frame_num_t'(hist_cnt) == max_frames)
	) else $error("done_read outside frame_st or before the last history frame");

endmodule

`default_nettype wire

/* src/oflow_fsm_write.sv */
// write controller of the frame history buffer
// frame counter, line counter of the current frame
// slot selection and end pointer per slot
`timescale 1ns/1ns
`default_nettype none

`include "oflow_buffer_config.svh"

module oflow_fsm_write (
	input wire logic clk,
	input wire logic reset_N,
	input wire oflow_frame_pkg::hist_cnt_t num_of_history_frames,
	input wire logic wr_line,
	input wire oflow_mem_pkg::line_t wr_data,
	input wire logic end_frame,
	input wire logic read_busy,
	output oflow_frame_pkg::frame_num_t frame_num,
	output oflow_frame_pkg::end_ptr_t end_pointers [`HIST_SLOTS],
	output logic mem_wr_en,
	output oflow_mem_pkg::mem_wr_t mem_wr
);

	// lines accepted in the frame being written
	oflow_frame_pkg::end_ptr_t wr_cnt;
	// count including a line accepted this cycle
	oflow_frame_pkg::end_ptr_t wr_cnt_next;
	oflow_mem_pkg::slot_t wr_slot;
	oflow_frame_pkg::frame_num_t slot_mod;

	// ------------------------------------------------------------
	// slot of the current frame and write request
	// ------------------------------------------------------------
	// frame f goes to slot f mod history count
	assign slot_mod = frame_num % oflow_frame_pkg::frame_num_t'(num_of_history_frames);
	assign wr_slot = oflow_mem_pkg::slot_t'(slot_mod);

	// drop lines once the slot is full
	assign mem_wr_en = wr_line && (wr_cnt < oflow_frame_pkg::end_ptr_t'(`SLOT_DEPTH));
	assign wr_cnt_next = mem_wr_en ? wr_cnt + oflow_frame_pkg::end_ptr_t'(1) : wr_cnt;

	always_comb begin
		mem_wr.addr.slot = wr_slot;
		// count is below SLOT_DEPTH whenever the write is enabled
		mem_wr.addr.offset = oflow_frame_pkg::offset_t'(wr_cnt);
		mem_wr.line = wr_data;
	end

	// ------------------------------------------------------------
	// counters and end pointers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wr_cnt <= '0;
			frame_num <= '0;
		end else if (end_frame) begin
			// new frame starts empty
			wr_cnt <= '0;
			frame_num <= frame_num + 1'b1;
		end else begin
			wr_cnt <= wr_cnt_next;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < `HIST_SLOTS; i++) begin
				end_pointers[i] <= '0;
			end
		end else if (end_frame) begin
			// a line on the closing cycle still counts
			end_pointers[wr_slot] <= wr_cnt_next;
		end
	end

	// history is frozen while the read controller walks it
	a_no_write_during_read: assert property (
		@(posedge clk) disable iff (!reset_N)
		read_busy |-> !wr_line && !end_frame
	) else $error("write activity while read is busy");

endmodule

`default_nettype wire

/* src/oflow_mem_pkg.sv */
// memory level types of the history buffer
// line data, slot index, address, write request, read result
`default_nettype none

`include "oflow_buffer_config.svh"

package oflow_mem_pkg;

	// one feature line
	typedef logic [`LINE_WIDTH-1:0] line_t;

	// slot index, enough for HIST_SLOTS
	typedef logic [$clog2(`HIST_SLOTS)-1:0] slot_t;

	// location of a line in the memory
	typedef struct packed {
		slot_t slot;
		oflow_frame_pkg::offset_t offset;
	} mem_addr_t;

	// write request from the write controller
	typedef struct packed {
		mem_addr_t addr;
		line_t line;
	} mem_wr_t;

	// read result, tagged with its frame and offset
	typedef struct packed {
		oflow_frame_pkg::frame_num_t frame;
		oflow_frame_pkg::offset_t offset;
		line_t line;
	} rd_line_t;

endpackage

`default_nettype wire

/* src/oflow_frame_pkg.sv */
// frame level types of the history buffer
// frame number, history count, line offset, end pointer
// read controller state encoding
`default_nettype none

`include "oflow_buffer_config.svh"

package oflow_frame_pkg;

	// serial number of a frame
	typedef logic [`TOTAL_FRAME_NUM_WIDTH-1:0] frame_num_t;

	// number of history frames, also the read frame counter
	typedef logic [`NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_cnt_t;

	// line offset inside one slot
	typedef logic [`OFFSET_WIDTH-1:0] offset_t;

	// lines held by a slot, 0..SLOT_DEPTH so one bit wider
	typedef logic [`OFFSET_WIDTH:0] end_ptr_t;

	// read controller states
	typedef enum logic [1:0] {
		idle_st,
		frame_st,
		offset_st
	} read_state_t;

endpackage

`default_nettype wire

/* src/oflow_buffer_config.svh */
// frame history buffer build constants
// widths of frame number, history count, line offset and line data
// slot count and slot depth
`ifndef OFLOW_BUFFER_CONFIG_SVH
`define OFLOW_BUFFER_CONFIG_SVH

// ------------------------------------------------------------
// frame level widths
// ------------------------------------------------------------
// frame serial number, wraps at 256
`define TOTAL_FRAME_NUM_WIDTH 8
// history count, programmed 1..HIST_SLOTS
`define NUM_OF_HISTORY_FRAMES_WIDTH 4

// ------------------------------------------------------------
// storage geometry
// ------------------------------------------------------------
`define HIST_SLOTS 5
`define OFFSET_WIDTH 4
// lines per slot, 2**OFFSET_WIDTH
`define SLOT_DEPTH 16
`define LINE_WIDTH 32

`endif
